//--- design/lib_arbiter_pkg.sv
// Pixel block sizes, address widths, vector typedefs and the readout event struct
package lib_arbiter_pkg;

    // Block geometry
    localparam int ROWS = 8;
    localparam int COLS = 8;

    // Address widths, log2 of the geometry
    localparam int ROW_ADD = 3;
    localparam int COL_ADD = 3;

    // One bit per row
    // Used for row requests and row grants
    typedef logic [ROWS-1:0] row_vec_t;

    // One bit per column
    // Used for hits, pending flags and clear strobes of one row
    typedef logic [COLS-1:0] col_vec_t;

    // Encoded row index
    typedef logic [ROW_ADD-1:0] row_addr_t;

    // Encoded column index
    typedef logic [COL_ADD-1:0] col_addr_t;

    // One read-out pixel
    // Row address sits in the upper bits
    typedef struct packed {
        row_addr_t row_add;
        col_addr_t col_add;
    } pixel_event_t;

    // Whole block, one col_vec_t per row
    // Index ROWS-1 is the top slice
    typedef col_vec_t [ROWS-1:0] hit_array_t;

endpackage

//--- design/priority_arb.sv
// Combinational fixed-priority arbiter with a one-hot grant
`timescale 1ns/1ps

module priority_arb
#(
    // Rows by default, columns when used in the encoder
    parameter int WIDTH = lib_arbiter_pkg::ROWS
)
(
    input  logic [WIDTH-1:0] req_i,
    output logic [WIDTH-1:0] gnt_o
);

    // Two's complement of the requests
    // Only the lowest set bit survives the AND
    logic [WIDTH-1:0] req_neg;

    assign req_neg = ~req_i + WIDTH'(1);

    // Lowest index wins
    // No requests gives an all-zero grant
    assign gnt_o = req_i & req_neg;

endmodule

//--- design/row_arbiter.sv
// Round-robin row arbiter with a registered one-hot grant and its encoded row index
`timescale 1ns/1ps

module row_arbiter
(
    input  logic                       clk_i,
    input  logic                       reset_i,
    input  logic                       enable_i,
    input  lib_arbiter_pkg::row_vec_t  req_i,
    output lib_arbiter_pkg::row_vec_t  gnt_o,
    output lib_arbiter_pkg::row_addr_t x_add_o
);

    // Rows still eligible in the current round
    lib_arbiter_pkg::row_vec_t mask_ff;
    lib_arbiter_pkg::row_vec_t nxt_mask;

    // Requests above the last winner
    lib_arbiter_pkg::row_vec_t mask_req;

    // Winners of the two fixed-priority stages
    lib_arbiter_pkg::row_vec_t mask_gnt;
    lib_arbiter_pkg::row_vec_t raw_gnt;

    // Grant to be registered at the next enabled edge
    lib_arbiter_pkg::row_vec_t gnt_next;

    // One-hot to index
    // Grant is one-hot so OR of the matching indices is enough
    function automatic lib_arbiter_pkg::row_addr_t encode_row(
        input lib_arbiter_pkg::row_vec_t onehot
    );
        lib_arbiter_pkg::row_addr_t idx;
        idx = '0;
        for (int i = 0; i < lib_arbiter_pkg::ROWS; i++)
        begin
            if (onehot[i])
            begin
                idx = idx | lib_arbiter_pkg::row_addr_t'(i);
            end
        end
        return idx;
    endfunction

    assign mask_req = req_i & mask_ff;

    // Stage on the masked requests
    priority_arb #(
        .WIDTH (lib_arbiter_pkg::ROWS)
    ) masked_arb_i (
        .req_i (mask_req),
        .gnt_o (mask_gnt)
    );

    // Stage on the raw requests, used once the round wraps
    priority_arb #(
        .WIDTH (lib_arbiter_pkg::ROWS)
    ) raw_arb_i (
        .req_i (req_i),
        .gnt_o (raw_gnt)
    );

    // Masked winner first, raw winner starts a new round
    assign gnt_next = (|mask_req) ? mask_gnt : raw_gnt;

    // Keep only the bits strictly above the winner
    // No winner gives an all-zero mask
    // Raw stage then picks the lowest requesting row
    assign nxt_mask = ~((gnt_next << 1) - lib_arbiter_pkg::row_vec_t'(1));

    always_ff @(posedge clk_i or posedge reset_i)
    begin
        if (reset_i)
        begin
            mask_ff <= '1;
            gnt_o   <= '0;
        end
        else if (enable_i)
        begin
            mask_ff <= nxt_mask;
            gnt_o   <= gnt_next;
        end
    end

    // Index of the held grant, 0 when nothing is granted
    assign x_add_o = encode_row(gnt_o);

endmodule

//--- design/pixel_row.sv
// One row of pixel pending flags with hit set, readout clear and a row request
`timescale 1ns/1ps

module pixel_row
(
    input  logic                      clk_i,
    input  logic                      reset_i,
    input  lib_arbiter_pkg::col_vec_t hit_i,
    input  lib_arbiter_pkg::col_vec_t clear_i,
    output lib_arbiter_pkg::col_vec_t pending_o,
    output logic                      req_o
);

    // Pending flag per pixel
    lib_arbiter_pkg::col_vec_t pending_q;
    lib_arbiter_pkg::col_vec_t pending_d;

    // Clear first, then set
    // A hit in the clear cycle keeps the pixel pending
    // Repeated hits on a pending pixel merge into one flag
    assign pending_d = (pending_q & ~clear_i) | hit_i;

    always_ff @(posedge clk_i or posedge reset_i)
    begin
        if (reset_i)
        begin
            pending_q <= '0;
        end
        else
        begin
            pending_q <= pending_d;
        end
    end

    assign pending_o = pending_q;

    // Row asks for readout while any pixel waits
    assign req_o = |pending_q;

endmodule

//--- design/readout_encoder.sv
// Readout encoder picking the lowest pending column of the granted row and clearing it
`timescale 1ns/1ps

module readout_encoder
(
    input  logic                          clk_i,
    input  logic                          reset_i,
    input  logic                          enable_i,
    input  lib_arbiter_pkg::row_vec_t     gnt_i,
    input  lib_arbiter_pkg::row_addr_t    row_add_i,
    input  lib_arbiter_pkg::hit_array_t   pending_i,
    output lib_arbiter_pkg::pixel_event_t event_o,
    output logic                          event_valid_o,
    output lib_arbiter_pkg::hit_array_t   clear_o
);

    // Pending vector of the granted row
    lib_arbiter_pkg::col_vec_t sel_pending;

    // One-hot winning column and its index
    lib_arbiter_pkg::col_vec_t  col_gnt;
    lib_arbiter_pkg::col_addr_t col_add;

    // An event goes out at this edge
    logic fire;

    // Column one-hot to index
    function automatic lib_arbiter_pkg::col_addr_t encode_col(
        input lib_arbiter_pkg::col_vec_t onehot
    );
        lib_arbiter_pkg::col_addr_t idx;
        idx = '0;
        for (int i = 0; i < lib_arbiter_pkg::COLS; i++)
        begin
            if (onehot[i])
            begin
                idx = idx | lib_arbiter_pkg::col_addr_t'(i);
            end
        end
        return idx;
    endfunction

    // No grant held means no row is selected
    assign sel_pending = (|gnt_i) ? pending_i[row_add_i] : '0;

    // Fixed priority over columns
    priority_arb #(
        .WIDTH (lib_arbiter_pkg::COLS)
    ) col_arb_i (
        .req_i (sel_pending),
        .gnt_o (col_gnt)
    );

    assign col_add = encode_col(col_gnt);

    // Granted row may have emptied already
    assign fire = enable_i & (|sel_pending);

    // Clear strobe lands on the same edge that registers the event
    always_comb
    begin
        for (int r = 0; r < lib_arbiter_pkg::ROWS; r++)
        begin
            clear_o[r] = (fire && gnt_i[r]) ? col_gnt : '0;
        end
    end

    // Event payload, held between events
    always_ff @(posedge clk_i)
    begin
        if (fire)
        begin
            event_o.row_add <= row_add_i;
            event_o.col_add <= col_add;
        end
    end

    // One valid strobe per emitted event
    always_ff @(posedge clk_i or posedge reset_i)
    begin
        if (reset_i)
        begin
            event_valid_o <= 1'b0;
        end
        else
        begin
            event_valid_o <= fire;
        end
    end

endmodule

//--- design/pixel_block_readout.sv
// Top level of the pixel block with its rows, the row arbiter and the readout encoder
`timescale 1ns/1ps

module pixel_block_readout
(
    input  logic                          clk_i,
    input  logic                          reset_i,
    input  logic                          readout_en_i,
    input  lib_arbiter_pkg::hit_array_t   hit_i,
    output lib_arbiter_pkg::pixel_event_t event_o,
    output logic                          event_valid_o
);

    // Pending flags of every row, toward the encoder
    lib_arbiter_pkg::hit_array_t pending;

    // Clear strobes from the encoder, one vector per row
    lib_arbiter_pkg::hit_array_t clear;

    // Row requests and the held row grant
    lib_arbiter_pkg::row_vec_t  row_req;
    lib_arbiter_pkg::row_vec_t  row_gnt;
    lib_arbiter_pkg::row_addr_t row_add;

    // One pixel_row per row of the block
    for (genvar r = 0; r < lib_arbiter_pkg::ROWS; r++)
    begin : g_row
        pixel_row row_i (
            .clk_i     (clk_i),
            .reset_i   (reset_i),
            .hit_i     (hit_i[r]),
            .clear_i   (clear[r]),
            .pending_o (pending[r]),
            .req_o     (row_req[r])
        );
    end

    // Arbitration stalls together with readout
    row_arbiter row_arb_i (
        .clk_i    (clk_i),
        .reset_i  (reset_i),
        .enable_i (readout_en_i),
        .req_i    (row_req),
        .gnt_o    (row_gnt),
        .x_add_o  (row_add)
    );

    readout_encoder enc_i (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .enable_i      (readout_en_i),
        .gnt_i         (row_gnt),
        .row_add_i     (row_add),
        .pending_i     (pending),
        .event_o       (event_o),
        .event_valid_o (event_valid_o),
        .clear_o       (clear)
    );

endmodule

//--- sim/tb_pixel_block_readout.sv
// Testbench for the pixel block readout with LFSR hits, a pending model and the test sequence
`timescale 1ns/1ps

module tb_pixel_block_readout;

    // DUT ports
    logic                          clk_i;
    logic                          reset_i;
    logic                          readout_en_i;
    lib_arbiter_pkg::hit_array_t   hit_i;
    lib_arbiter_pkg::pixel_event_t event_o;
    logic                          event_valid_o;

    // Model of the pending flags
    lib_arbiter_pkg::hit_array_t model_pending;
    int                          pending_count;

    // Fibonacci LFSR state
    logic [31:0] lfsr_state;

    // Checking modes of the observer
    logic  expect_quiet;
    logic  check_order;
    int    order_index;
    string test_name;

    pixel_block_readout dut_i (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .readout_en_i  (readout_en_i),
        .hit_i         (hit_i),
        .event_o       (event_o),
        .event_valid_o (event_valid_o)
    );

    // 40 ns period
    initial
    begin
        clk_i = 1'b0;
        forever
        begin
            #20 clk_i = ~clk_i;
        end
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        logic feedback;
        feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
        return {state[30:0], feedback};
    endfunction

    // One LFSR step per bit taken
    task automatic take_bits(input int count, output int value);
        value = 0;
        for (int i = 0; i < count; i++)
        begin
            lfsr_state = lfsr_step(lfsr_state);
            value = (value << 1) | int'(lfsr_state[0]);
        end
    endtask

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("ERRORS FOUND");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input int expected, input int actual);
        if (expected != actual)
        begin
            stop_with_failure($sformatf("FAILED %s expected %0d actual %0d",
                                        name, expected, actual));
        end
    endtask

    // Compare one output cycle with the model
    task automatic observe_event();
        lib_arbiter_pkg::row_addr_t row;
        lib_arbiter_pkg::col_addr_t col;
        if (expect_quiet)
        begin
            check_value({test_name, " valid"}, 0, int'(event_valid_o));
        end
        if (event_valid_o)
        begin
            row = event_o.row_add;
            col = event_o.col_add;
            // Event has to name a pixel the model holds
            check_value({test_name, " pending"}, 1, int'(model_pending[row][col]));
            model_pending[row][col] = 1'b0;
            pending_count--;
            if (check_order)
            begin
                // Rows take turns, each row drains lowest column first
                check_value({test_name, " row"}, order_index % lib_arbiter_pkg::ROWS,
                            int'(row));
                check_value({test_name, " column"}, order_index / lib_arbiter_pkg::ROWS,
                            int'(col));
                order_index++;
            end
        end
    endtask

    // Step past an edge, observe, then release the hit pulses
    task automatic next_cycle();
        @(posedge clk_i);
        #2;
        observe_event();
        hit_i = '0;
    endtask

    // Up to two sparse hits, only on pixels the model holds clear
    task automatic inject_random_hits();
        int go;
        int row;
        int col;
        for (int t = 0; t < 2; t++)
        begin
            take_bits(2, go);
            take_bits(3, row);
            take_bits(3, col);
            if (go == 3 && !model_pending[row][col])
            begin
                hit_i[row][col] = 1'b1;
                model_pending[row][col] = 1'b1;
                pending_count++;
            end
        end
    endtask

    task automatic run_random_hits(input int cycles);
        for (int i = 0; i < cycles; i++)
        begin
            next_cycle();
            inject_random_hits();
        end
    endtask

    // Wait for the model to empty
    task automatic drain_model(input int limit);
        int waited;
        waited = 0;
        while (pending_count > 0)
        begin
            if (waited >= limit)
            begin
                stop_with_failure($sformatf(
                    "Readout stalled with %0d pixels still pending after %0d cycles",
                    pending_count, limit));
            end
            next_cycle();
            waited++;
        end
    endtask

    // No event may show up
    task automatic quiet_cycles(input string name, input int cycles);
        test_name = name;
        expect_quiet = 1'b1;
        for (int i = 0; i < cycles; i++)
        begin
            next_cycle();
        end
        expect_quiet = 1'b0;
    endtask

    // Every clear pixel of the block hit at once
    task automatic inject_all_pixels();
        for (int r = 0; r < lib_arbiter_pkg::ROWS; r++)
        begin
            for (int c = 0; c < lib_arbiter_pkg::COLS; c++)
            begin
                if (!model_pending[r][c])
                begin
                    hit_i[r][c] = 1'b1;
                    model_pending[r][c] = 1'b1;
                    pending_count++;
                end
            end
        end
    endtask

    initial
    begin
        int drain_limit;
        drain_limit   = lib_arbiter_pkg::ROWS * lib_arbiter_pkg::COLS * 4;
        reset_i       = 1'b1;
        readout_en_i  = 1'b0;
        hit_i         = '0;
        model_pending = '0;
        pending_count = 0;
        lfsr_state    = 32'd87554;
        expect_quiet  = 1'b0;
        check_order   = 1'b0;
        order_index   = 0;
        test_name     = "reset";

        // Reset for 10 cycles
        repeat (10) @(posedge clk_i);
        #2;
        reset_i      = 1'b0;
        readout_en_i = 1'b1;

        quiet_cycles("idle after reset", 20);

        // Sparse random hits, each read out once
        test_name = "exactly once";
        run_random_hits(300);
        drain_model(drain_limit);
        quiet_cycles("idle after drain", 20);

        // Stall with pixels pending and hits still arriving
        test_name = "stall";
        run_random_hits(100);
        readout_en_i = 1'b0;
        expect_quiet = 1'b1;
        for (int i = 0; i < 30; i++)
        begin
            next_cycle();
            inject_random_hits();
        end
        expect_quiet = 1'b0;
        readout_en_i = 1'b1;
        test_name = "stall drain";
        drain_model(drain_limit);
        quiet_cycles("idle after stall", 20);

        // Full block loaded while stalled
        test_name = "round robin";
        next_cycle();
        readout_en_i = 1'b0;
        inject_all_pixels();
        quiet_cycles("round robin load", 5);
        readout_en_i = 1'b1;
        test_name   = "round robin";
        check_order = 1'b1;
        order_index = 0;
        drain_model(drain_limit);
        check_order = 1'b0;
        quiet_cycles("idle after round robin", 20);

        // Closing random burst
        test_name = "final drain";
        run_random_hits(200);
        drain_model(drain_limit);
        quiet_cycles("idle at end", 20);

        $display("NO ERRORS");
        $finish;
    end

endmodule

//--- list.f
design/lib_arbiter_pkg.sv
design/priority_arb.sv
design/row_arbiter.sv
design/pixel_row.sv
design/readout_encoder.sv
design/pixel_block_readout.sv
sim/tb_pixel_block_readout.sv

//--- Makefile
# Verilator build for the pixel block readout

TB_TOP = tb_pixel_block_readout
LOG    = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f list.f --top-module pixel_block_readout

sim:
	verilator --binary --timing -f list.f --top-module $(TB_TOP) -o $(TB_TOP)
	-./obj_dir/$(TB_TOP) > $(LOG) 2>&1
	cat $(LOG)
	@if grep -q "ERRORS FOUND" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi
	@if ! grep -q "NO ERRORS" $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; \
		exit 1; \
	fi
	@echo "Simulation passed"

clean:
	rm -rf obj_dir $(LOG)
